//--- logic/sd_spi_pkg.sv
//********************
// Shared constants and types for the SD SPI transmit path.
// CRC polynomials hold the taps only; the top power is implicit.
// Block length is a module parameter, not a constant here.
//********************

package sd_spi_pkg;

  // Command frame layout
  // Start, transmission, 6-bit index and 32-bit argument
  localparam int CMD_BODY_BITS = 40;
  // Body, CRC7 and end bit
  localparam int CMD_FRAME_BITS = 48;

  // CRC7 for commands, x^7 + x^3 + 1
  localparam int CRC7_WIDTH = 7;
  localparam logic [CRC7_WIDTH-1:0] CRC7_POLY = 7'h09;

  // CRC16 CCITT for data blocks, x^16 + x^12 + x^5 + 1
  localparam int CRC16_WIDTH = 16;
  localparam logic [CRC16_WIDTH-1:0] CRC16_POLY = 16'h1021;

  // Start token ahead of a single-block payload
  localparam logic [7:0] DATA_TOKEN = 8'hfe;
  localparam int TOKEN_BITS = 8;

  // What the controller hands over
  typedef enum logic {
    frame_cmd  = 1'b0,
    frame_data = 1'b1
  } frame_kind_t;

endpackage

//--- logic/sd_crc_serial.sv
//********************
// Bit-serial CRC, one bit per enabled clock, zero initial value.
// After the body it streams the remainder out MSB first.
// Clear wins over enable.
//********************

`timescale 1ns/10ps

module sd_crc_serial #(
  parameter int WIDTH = 7,
  parameter logic [WIDTH-1:0] POLY = 7'h09
) (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic enable,
  input  logic absorb,
  input  logic bit_in,
  output logic crc_bit
);

  logic [WIDTH-1:0] crc;
  logic feedback;
  logic [WIDTH-1:0] crc_next;

  // Galois form, the feedback taps XOR into the shifted remainder
  assign feedback = crc[WIDTH-1] ^ bit_in;

  always_comb begin
    if (absorb) begin
      crc_next = {crc[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);
    end else begin
      // Readout, ones fill in behind the remainder
      crc_next = {crc[WIDTH-2:0], 1'b1};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      crc <= '0;
    end else if (clear) begin
      crc <= '0;
    end else if (enable) begin
      crc <= crc_next;
    end
  end

  assign crc_bit = crc[WIDTH-1];

endmodule

//--- logic/sd_frame_shifter.sv
//********************
// Frame register and bit counter for one command or data frame.
// Payload goes out from the top byte of data down.
// Holds at most one frame; load is only taken while idle.
// Needs BLOCK_BYTES of 4 or more so a command fits the register.
//********************

`timescale 1ns/10ps

module sd_frame_shifter
  import sd_spi_pkg::*;
#(
  parameter int BLOCK_BYTES = 512,
  localparam int DATA_FRAME_BITS = TOKEN_BITS + 8 * BLOCK_BYTES + CRC16_WIDTH,
  localparam int CNT_WIDTH = $clog2(DATA_FRAME_BITS + 1)
) (
  input  logic clock,
  input  logic reset,
  input  logic load,
  input  frame_kind_t kind,
  input  logic [5:0] cmd_index,
  input  logic [31:0] argument,
  input  logic [8*BLOCK_BYTES-1:0] data,
  input  logic shift,
  output logic head,
  output logic [CNT_WIDTH-1:0] bits_left,
  output logic last
);

  // Token plus payload; CRC bits come from the CRC blocks
  localparam int REG_BITS = TOKEN_BITS + 8 * BLOCK_BYTES;
  localparam int PAD_BITS = REG_BITS - CMD_BODY_BITS;

  localparam logic [CNT_WIDTH-1:0] CMD_COUNT = CNT_WIDTH'(CMD_FRAME_BITS);
  localparam logic [CNT_WIDTH-1:0] DATA_COUNT = CNT_WIDTH'(DATA_FRAME_BITS);

  logic [REG_BITS-1:0] frame;
  logic [REG_BITS-1:0] load_value;
  logic [CMD_BODY_BITS-1:0] cmd_body;

  // Start bit 0, transmission bit 1, then index and argument
  assign cmd_body = {1'b0, 1'b1, cmd_index, argument};

  always_comb begin
    if (kind == frame_data) begin
      load_value = {DATA_TOKEN, data};
    end else begin
      // Command left aligned, rest of the register filled with ones
      load_value = {cmd_body, {PAD_BITS{1'b1}}};
    end
  end

  // Frame register, ones shift in behind the outgoing bits
  always_ff @(posedge clock) begin
    if (load) begin
      frame <= load_value;
    end else if (shift) begin
      frame <= {frame[REG_BITS-2:0], 1'b1};
    end
  end

  // Counts the bits still to go, the current one included
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bits_left <= '0;
    end else if (load) begin
      bits_left <= (kind == frame_data) ? DATA_COUNT : CMD_COUNT;
    end else if (shift && bits_left != '0) begin
      bits_left <= bits_left - CNT_WIDTH'(1);
    end
  end

  assign head = frame[REG_BITS-1];
  assign last = (bits_left == CNT_WIDTH'(1));

endmodule

//--- logic/sd_sender.sv
//********************
// Idle/sending control for one frame at a time, no back-pressure.
// First bit on mosi the cycle after acceptance; mosi idles high.
// valid while busy is dropped, not queued.
//********************

`timescale 1ns/10ps

module sd_sender
  import sd_spi_pkg::*;
#(
  parameter int BLOCK_BYTES = 512,
  localparam int DATA_FRAME_BITS = TOKEN_BITS + 8 * BLOCK_BYTES + CRC16_WIDTH,
  localparam int CNT_WIDTH = $clog2(DATA_FRAME_BITS + 1)
) (
  input  logic clock,
  input  logic reset,
  input  logic [5:0] cmd_index,
  input  logic [31:0] argument,
  input  frame_kind_t kind,
  input  logic [8*BLOCK_BYTES-1:0] data,
  input  logic valid,
  output logic ready,
  output logic mosi
);

  // Phase boundaries in terms of bits still to go
  localparam logic [CNT_WIDTH-1:0] CMD_TAIL = CNT_WIDTH'(CMD_FRAME_BITS - CMD_BODY_BITS);
  localparam logic [CNT_WIDTH-1:0] DATA_BODY_TOP = CNT_WIDTH'(DATA_FRAME_BITS - TOKEN_BITS);
  localparam logic [CNT_WIDTH-1:0] DATA_CRC_TOP = CNT_WIDTH'(CRC16_WIDTH);

  typedef enum logic {
    st_idle,
    st_sending
  } state_t;

  state_t state;
  state_t next_state;
  frame_kind_t kind_reg;

  logic accept;
  logic sending;
  logic head;
  logic [CNT_WIDTH-1:0] bits_left;
  logic last;
  logic crc7_bit;
  logic crc16_bit;

  logic is_cmd;
  logic cmd_body;
  logic cmd_crc;
  logic data_token;
  logic data_crc;
  logic data_body;

  assign ready = (state == st_idle);
  assign sending = (state == st_sending);
  assign accept = ready & valid;

  always_comb begin
    next_state = state;
    case (state)
      st_idle: if (valid) next_state = st_sending;
      st_sending: if (last) next_state = st_idle;
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
      kind_reg <= frame_cmd;
    end else begin
      state <= next_state;
      if (accept) kind_reg <= kind;
    end
  end

  sd_frame_shifter #(
    .BLOCK_BYTES(BLOCK_BYTES)
  ) shifter (
    .clock(clock),
    .reset(reset),
    .load(accept),
    .kind(kind),
    .cmd_index(cmd_index),
    .argument(argument),
    .data(data),
    .shift(sending),
    .head(head),
    .bits_left(bits_left),
    .last(last)
  );

  // Command: 40 body bits, 7 CRC bits, end bit
  assign is_cmd = (kind_reg == frame_cmd);
  assign cmd_body = is_cmd && (bits_left > CMD_TAIL);
  assign cmd_crc = is_cmd && !cmd_body && !last;

  // Data: token, payload, 16 CRC bits
  assign data_token = !is_cmd && (bits_left > DATA_BODY_TOP);
  assign data_crc = !is_cmd && (bits_left <= DATA_CRC_TOP);
  assign data_body = !is_cmd && !data_token && !data_crc;

  // CRC16 stays still over the token so it only covers the payload
  sd_crc_serial #(
    .WIDTH(CRC7_WIDTH),
    .POLY(CRC7_POLY)
  ) crc7_gen (
    .clock(clock),
    .reset(reset),
    .clear(accept),
    .enable(sending && is_cmd),
    .absorb(cmd_body),
    .bit_in(mosi),
    .crc_bit(crc7_bit)
  );

  sd_crc_serial #(
    .WIDTH(CRC16_WIDTH),
    .POLY(CRC16_POLY)
  ) crc16_gen (
    .clock(clock),
    .reset(reset),
    .clear(accept),
    .enable(sending && !is_cmd && !data_token),
    .absorb(data_body),
    .bit_in(mosi),
    .crc_bit(crc16_bit)
  );

  always_comb begin
    if (!sending) begin
      mosi = 1'b1;
    end else if (cmd_body || data_token || data_body) begin
      mosi = head;
    end else if (cmd_crc) begin
      mosi = crc7_bit;
    end else if (data_crc) begin
      mosi = crc16_bit;
    end else begin
      mosi = 1'b1;  // command end bit
    end
  end

endmodule

//--- logic/sd_spi_tx.sv
//********************
// Transmit side of an SPI-mode SD host, one bit per clock.
// No chip select, SPI clock or receive path.
//********************

`timescale 1ns/10ps

module sd_spi_tx
  import sd_spi_pkg::*;
#(
  parameter int BLOCK_BYTES = 512
) (
  input  logic clock,
  input  logic reset,
  input  logic [5:0] cmd_index,
  input  logic [31:0] argument,
  input  frame_kind_t kind,
  input  logic [8*BLOCK_BYTES-1:0] data,
  input  logic valid,
  output logic ready,
  output logic mosi
);

  sd_sender #(
    .BLOCK_BYTES(BLOCK_BYTES)
  ) sender (
    .clock(clock),
    .reset(reset),
    .cmd_index(cmd_index),
    .argument(argument),
    .kind(kind),
    .data(data),
    .valid(valid),
    .ready(ready),
    .mosi(mosi)
  );

endmodule

//--- testbench/sd_spi_tx_properties.sv
//********************
// Assertions on the sender control, bound into sd_sender.
// Failures are also counted for the testbench summary.
//********************

`timescale 1ns/10ps

module sd_spi_tx_properties
  import sd_spi_pkg::*;
#(
  parameter int CNT_WIDTH = 8
) (
  input logic clock,
  input logic reset,
  input logic valid,
  input logic ready,
  input logic mosi,
  input logic last,
  input frame_kind_t kind_reg,
  input logic [CNT_WIDTH-1:0] bits_left
);

  int failures;

  // Idle means a high line and no bits left over
  idle_line_high: assert property (@(posedge clock) disable iff (reset)
    ready |-> mosi && bits_left == '0)
    else begin
      $error("mosi is low or bits are still pending while ready is high");
      failures++;
    end

  busy_after_accept: assert property (@(posedge clock) disable iff (reset)
    ready && valid |=> !ready)
    else begin
      $error("ready did not fall after an accepted frame");
      failures++;
    end

  // Strobes while busy must not touch the frame in flight
  busy_strobe_kind: assert property (@(posedge clock) disable iff (reset)
    !ready && valid |=> $stable(kind_reg))
    else begin
      $error("frame kind changed on a strobe while busy");
      failures++;
    end

  busy_strobe_count: assert property (@(posedge clock) disable iff (reset)
    !ready && valid && !last |=> !ready && bits_left == $past(bits_left) - CNT_WIDTH'(1))
    else begin
      $error("bit counter did not step down on a strobe while busy");
      failures++;
    end

endmodule

bind sd_sender sd_spi_tx_properties #(
  .CNT_WIDTH(CNT_WIDTH)
) props0 (
  .clock(clock),
  .reset(reset),
  .valid(valid),
  .ready(ready),
  .mosi(mosi),
  .last(last),
  .kind_reg(kind_reg),
  .bits_left(bits_left)
);

//--- testbench/sd_spi_tx_checker.sv
//********************
// Reference model for the SD SPI transmit path.
// Samples everything on the falling edge; one frame at a time.
// Payload goes out from the top byte of data down.
//********************

`timescale 1ns/10ps

module sd_spi_tx_checker
  import sd_spi_pkg::*;
#(
  parameter int BLOCK_BYTES = 512
) (
  input  logic clock,
  input  logic reset,
  input  logic [5:0] cmd_index,
  input  logic [31:0] argument,
  input  frame_kind_t kind,
  input  logic [8*BLOCK_BYTES-1:0] data,
  input  logic valid,
  input  logic ready,
  input  logic mosi,
  output int frame_count,
  output int data_errors,
  output int timing_errors
);

  localparam int PAYLOAD_BITS = 8 * BLOCK_BYTES;
  localparam int CMD_LEN = 48;
  localparam int DATA_LEN = 8 + PAYLOAD_BITS + 16;

  // x^7+x^3+1 and x^16+x^12+x^5+1, top term implicit
  localparam logic [6:0] CRC7_TAPS = 7'h09;
  localparam logic [15:0] CRC16_TAPS = 16'h1021;

  logic busy;
  logic is_cmd0;
  int length;
  int position;
  logic [DATA_LEN-1:0] expected;
  logic [DATA_LEN-1:0] captured;
  logic [39:0] body;

  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic fb;
    int i;
    crc = '0;
    for (i = 39; i >= 0; i--) begin
      fb = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ CRC7_TAPS;
    end
    return crc;
  endfunction

  function automatic logic [15:0] crc16_of(input logic [PAYLOAD_BITS-1:0] bits);
    logic [15:0] crc;
    logic fb;
    int i;
    crc = '0;
    for (i = PAYLOAD_BITS - 1; i >= 0; i--) begin
      fb = crc[15] ^ bits[i];
      crc = {crc[14:0], 1'b0};
      if (fb) crc = crc ^ CRC16_TAPS;
    end
    return crc;
  endfunction

  initial begin
    busy = 1'b0;
    frame_count = 0;
    data_errors = 0;
    timing_errors = 0;
  end

  // Mid cycle, so inputs and DUT outputs are both settled
  always @(negedge clock) begin
    if (reset) begin
      busy = 1'b0;
    end else if (busy) begin
      if (ready !== 1'b0) begin
        timing_errors++;
        $display("ERROR ready in frame %0d bit %0d: expected %h, got %h",
                 frame_count, position, 1'b0, ready);
      end
      captured = {captured[DATA_LEN-2:0], mosi};
      position++;
      if (position == length) begin
        busy = 1'b0;
        if (captured !== expected) begin
          data_errors++;
          $display("ERROR mosi in frame %0d: expected %h, got %h",
                   frame_count, expected, captured);
        end
        // CMD0 always ends in 95 hex
        if (is_cmd0 && captured[7:0] !== 8'h95) begin
          data_errors++;
          $display("ERROR mosi last byte of CMD0: expected %h, got %h", 8'h95, captured[7:0]);
        end
      end
    end else begin
      if (ready !== 1'b1) begin
        timing_errors++;
        $display("ERROR ready while idle: expected %h, got %h", 1'b1, ready);
      end
      if (mosi !== 1'b1) begin
        timing_errors++;
        $display("ERROR mosi while idle: expected %h, got %h", 1'b1, mosi);
      end
      if (valid === 1'b1 && ready === 1'b1) begin
        frame_count++;
        busy = 1'b1;
        position = 0;
        captured = '0;
        expected = '0;
        is_cmd0 = (kind == frame_cmd) && (cmd_index == 6'd0) && (argument == 32'd0);
        if (kind == frame_data) begin
          length = DATA_LEN;
          expected = {8'hfe, data, crc16_of(data)};
        end else begin
          length = CMD_LEN;
          body = {1'b0, 1'b1, cmd_index, argument};
          expected[CMD_LEN-1:0] = {body, crc7_of(body), 1'b1};
        end
      end
    end
  end

endmodule

//--- testbench/sd_spi_tx_tb.sv
//********************
// Random frames of both kinds, 16-byte blocks, fixed LFSR seed.
// Strobes valid at random while the sender is busy.
//********************

`timescale 1ns/10ps

module sd_spi_tx_tb
  import sd_spi_pkg::*;
;

  localparam int BLOCK_BYTES = 16;
  localparam int FRAMES = 60;
  localparam int READY_TIMEOUT = 400;

  logic clock;
  logic reset;
  logic [5:0] cmd_index;
  logic [31:0] argument;
  frame_kind_t kind;
  logic [8*BLOCK_BYTES-1:0] data;
  logic valid;
  logic ready;
  logic mosi;

  logic [31:0] lfsr;
  logic timed_out;
  logic ok;
  logic [31:0] value;
  int frames_sent;
  int other_errors;
  int total;
  int n;
  int checked_frames;
  int data_errors;
  int timing_errors;

  sd_spi_tx #(
    .BLOCK_BYTES(BLOCK_BYTES)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .cmd_index(cmd_index),
    .argument(argument),
    .kind(kind),
    .data(data),
    .valid(valid),
    .ready(ready),
    .mosi(mosi)
  );

  sd_spi_tx_checker #(
    .BLOCK_BYTES(BLOCK_BYTES)
  ) checker0 (
    .clock(clock),
    .reset(reset),
    .cmd_index(cmd_index),
    .argument(argument),
    .kind(kind),
    .data(data),
    .valid(valid),
    .ready(ready),
    .mosi(mosi),
    .frame_count(checked_frames),
    .data_errors(data_errors),
    .timing_errors(timing_errors)
  );

  always #2 clock = ~clock;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic load_random_frame();
    logic [31:0] bits;
    int i;
    draw_bits(1, bits);
    kind = bits[0] ? frame_data : frame_cmd;
    draw_bits(6, bits);
    cmd_index = bits[5:0];
    draw_bits(32, bits);
    argument = bits;
    for (i = 0; i < BLOCK_BYTES; i++) begin
      draw_bits(8, bits);
      data[8*i +: 8] = bits[7:0];
    end
  endtask

  // Called with ready high, just after an edge
  task automatic send_current();
    valid = 1'b1;
    @(posedge clock);
    #0.5;
    valid = 1'b0;
    frames_sent++;
  endtask

  task automatic wait_for_ready(output logic done);
    logic [31:0] bits;
    int waited;
    waited = 0;
    done = 1'b1;
    while (ready !== 1'b1 && done) begin
      // About one strobe in four, with junk on the inputs
      draw_bits(2, bits);
      valid = (bits[1:0] == 2'b11);
      if (valid) load_random_frame();
      @(posedge clock);
      #0.5;
      waited++;
      if (waited > READY_TIMEOUT) done = 1'b0;
    end
    valid = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    valid = 1'b0;
    kind = frame_cmd;
    cmd_index = '0;
    argument = '0;
    data = '0;
    lfsr = 32'hdf52;
    timed_out = 1'b0;
    frames_sent = 0;
    other_errors = 0;
    repeat (16) @(posedge clock);
    #0.5;
    reset = 1'b0;
    repeat (4) begin
      @(posedge clock);
      #0.5;
    end

    // CMD0 first
    kind = frame_cmd;
    cmd_index = 6'd0;
    argument = 32'd0;
    send_current();

    for (n = 0; n < FRAMES && !timed_out; n++) begin
      wait_for_ready(ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("Timeout: ready did not return within %0d cycles", READY_TIMEOUT);
      end else begin
        // Mostly back to back, sometimes a short gap
        draw_bits(2, value);
        if (value[1:0] == 2'b00) begin
          repeat (2) begin
            @(posedge clock);
            #0.5;
          end
        end
        load_random_frame();
        send_current();
      end
    end

    if (!timed_out) begin
      wait_for_ready(ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("Timeout: last frame did not finish within %0d cycles", READY_TIMEOUT);
      end
    end
    repeat (2) @(posedge clock);

    if (frames_sent != checked_frames) begin
      other_errors++;
      $display("Frame count mismatch: %0d sent, %0d seen by the checker",
               frames_sent, checked_frames);
    end
    total = data_errors + timing_errors + other_errors + dut0.sender.props0.failures;
    if (timed_out) total++;
    $display("Frames %0d, data errors %0d, timing errors %0d, other errors %0d, assertions %0d",
             checked_frames, data_errors, timing_errors, other_errors,
             dut0.sender.props0.failures);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- all.f
logic/sd_spi_pkg.sv
logic/sd_crc_serial.sv
logic/sd_frame_shifter.sv
logic/sd_sender.sv
logic/sd_spi_tx.sv
testbench/sd_spi_tx_properties.sv
testbench/sd_spi_tx_checker.sv
testbench/sd_spi_tx_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := sd_spi_tx_tb
FILE_LIST := all.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
SIM_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
PASS_TEXT := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
